// File: vlog.f
rtl/cmp_rx_pkg.sv
rtl/cmp_frame_if.sv
rtl/cmp_rx_link_ctrl.sv
rtl/cmp_frame_assembler.sv
rtl/cmp_prbs_checker.sv
rtl/cmp_fiber_rx.sv
testbench/cmp_fiber_tx_model.sv
testbench/tb_cmp_fiber_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fiber receive testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module tb_cmp_fiber_rx -Mdir "$obj" -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$obj/Vtb_cmp_fiber_rx" | tee "$log"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
	echo "Simulation exited with an error"
	exit 1
fi

if grep -q "tests failed" "$log"; then
	echo "FAIL"
	exit 1
fi
echo "PASS"
exit 0

// File: testbench/tb_cmp_fiber_rx.sv
`default_nettype none

module tb_cmp_fiber_rx;

	timeunit 1ns;
	timeprecision 1ps;

	logic        CMP_RX_CLK160;
	logic        cmp_rx_resetdone;
	logic        rst;
	logic        rx_byte_aligned;
	logic [15:0] rx_data;
	logic [1:0]  rx_isk;
	logic        calign_en;
	logic        enpmaphasealign;
	logic        pmasetphase;
	logic        dlyaligndisable;
	logic        dlyalignreset;
	logic        sync_done;
	logic [47:0] rcv_data;
	logic [2:0]  nonzero_word;
	logic        ltncy_trig;
	logic        strt_mtch;
	logic        valid;
	logic        match;

	// Frames in flight with the oldest at the front
	logic [47:0] exp_data_q[$];
	logic        exp_ltncy_q[$];
	// Reference checker state and next-edge expectations
	logic        ref_locked;
	logic [47:0] ref_pred;
	logic        exp_strt;
	logic        exp_valid;
	logic        exp_match;
	logic        aligned_q;
	// Pulse counters
	int strt_cnt;
	int valid_cnt;
	int match_cnt;
	// Run bookkeeping
	int err_cnt;
	int test_cnt;
	int fail_cnt;

	// Assembler strobe taken from inside the DUT
	wire frame_ready_mon = cmp_fiber_rx_inst.frame_if.frame_ready;

	cmp_fiber_rx cmp_fiber_rx_inst (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rst              (rst),
		.rx_data          (rx_data),
		.rx_isk           (rx_isk),
		.rx_byte_aligned  (rx_byte_aligned),
		.calign_en        (calign_en),
		.enpmaphasealign  (enpmaphasealign),
		.pmasetphase      (pmasetphase),
		.dlyaligndisable  (dlyaligndisable),
		.dlyalignreset    (dlyalignreset),
		.sync_done        (sync_done),
		.rcv_data         (rcv_data),
		.nonzero_word     (nonzero_word),
		.ltncy_trig       (ltncy_trig),
		.strt_mtch        (strt_mtch),
		.valid            (valid),
		.match            (match)
	);

	cmp_fiber_tx_model tx_model_inst (
		.CMP_RX_CLK160 (CMP_RX_CLK160),
		.rx_data       (rx_data),
		.rx_isk        (rx_isk)
	);

	// 100 MHz stand-in for the recovered clock
	initial begin
		CMP_RX_CLK160 = 1'b0;
		forever #5 CMP_RX_CLK160 = ~CMP_RX_CLK160;
	end

	//--------------------------------------------------------------------
	// Reporting and reference helpers
	//--------------------------------------------------------------------
	function automatic void report_mismatch(string name, logic [47:0] expected,
		logic [47:0] actual);
		err_cnt++;
		$display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
	endfunction

	function automatic void log_failure(string what);
		err_cnt++;
		$display("Failure at %0t ns: %s", $time, what);
	endfunction

	// Shift up with the parity of the tapped bits as the new bit
	function automatic logic [47:0] lfsr_step(input logic [47:0] v);
		logic [47:0] taps;
		taps = '0;
		taps[cmp_rx_pkg::prbs_tap_hi] = 1'b1;
		taps[cmp_rx_pkg::prbs_tap_a]  = 1'b1;
		taps[cmp_rx_pkg::prbs_tap_b]  = 1'b1;
		taps[cmp_rx_pkg::prbs_tap_lo] = 1'b1;
		return {v[46:0], ^(v & taps)};
	endfunction

	task automatic finish_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: FAILED, %0d errors", test_cnt, name, err_cnt - errs_before);
		end
	endtask

	// Queue the expected result before the words go out
	task automatic send_checked(input cmp_rx_pkg::k_code_e k, input logic [47:0] payload);
		exp_data_q.push_back(payload);
		exp_ltncy_q.push_back(k == cmp_rx_pkg::k_latency);
		tx_model_inst.send_frame(k, payload[15:0], payload[31:16], payload[47:32]);
	endtask

	// Wait for all queued frames and the checker pulse after the last
	task automatic drain();
		int n;
		for (n = 0; n < 40 && exp_data_q.size() != 0; n++)
			@(posedge CMP_RX_CLK160);
		if (exp_data_q.size() != 0)
			log_failure("sent frames were never published");
		repeat (2) @(posedge CMP_RX_CLK160);
		#1;
	endtask

	//--------------------------------------------------------------------
	// Frame monitor and checker model
	//--------------------------------------------------------------------
	always @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		logic [47:0] f;
		logic [2:0]  nz;
		logic        lt;
		f  = '0;
		nz = '0;
		lt = 1'b0;
		if (!cmp_rx_resetdone) begin
			ref_locked <= 1'b0;
			ref_pred   <= '0;
			exp_strt   <= 1'b0;
			exp_valid  <= 1'b0;
			exp_match  <= 1'b0;
			aligned_q  <= 1'b0;
			strt_cnt   = 0;
			valid_cnt  = 0;
			match_cnt  = 0;
		end else begin
			aligned_q <= rx_byte_aligned;
			if (strt_mtch)
				strt_cnt++;
			if (valid)
				valid_cnt++;
			if (match)
				match_cnt++;
			// Published frame against the oldest one sent
			if (frame_ready_mon) begin
				if (exp_data_q.size() == 0) begin
					log_failure("frame published with no frame sent");
				end else begin
					f  = exp_data_q.pop_front();
					lt = exp_ltncy_q.pop_front();
					nz = {|f[47:32], |f[31:16], |f[15:0]};
					assert (rcv_data == f)
						else report_mismatch("rcv_data", f, rcv_data);
					assert (nonzero_word == nz)
						else report_mismatch("nonzero_word", 48'(nz), 48'(nonzero_word));
					assert (ltncy_trig == lt)
						else report_mismatch("ltncy_trig", 48'(lt), 48'(ltncy_trig));
				end
			end
			// Pulses expected one edge after the strobe
			exp_strt  <= 1'b0;
			exp_valid <= 1'b0;
			exp_match <= 1'b0;
			if (rst) begin
				ref_locked <= 1'b0;
			end else if (frame_ready_mon) begin
				if (!ref_locked) begin
					if (f == cmp_rx_pkg::prbs_start_pattern) begin
						exp_strt   <= 1'b1;
						ref_locked <= 1'b1;
						ref_pred   <= lfsr_step(f);
					end
				end else begin
					exp_valid <= 1'b1;
					exp_match <= (f == ref_pred);
					ref_pred  <= lfsr_step(ref_pred);
				end
			end
		end
	end

	//--------------------------------------------------------------------
	// Concurrent checks
	//--------------------------------------------------------------------
	// Comma search tracks byte alignment one edge late
	assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		calign_en == !aligned_q)
		else report_mismatch("calign_en", 48'(!$sampled(aligned_q)), 48'($sampled(calign_en)));
	// Sequencer order
	assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		enpmaphasealign |-> !dlyalignreset)
		else log_failure("phase alignment enabled while delay aligner still in reset");
	assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		$rose(sync_done) |-> $past(pmasetphase))
		else log_failure("sync_done rose without a pmasetphase pulse before it");
	assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		sync_done |=> sync_done)
		else log_failure("sync_done dropped after link up");
	// Checker pulses against the model
	assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		strt_mtch == exp_strt)
		else report_mismatch("strt_mtch", 48'($sampled(exp_strt)), 48'($sampled(strt_mtch)));
	assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		valid == exp_valid)
		else report_mismatch("valid", 48'($sampled(exp_valid)), 48'($sampled(valid)));
	assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
		match == exp_match)
		else report_mismatch("match", 48'($sampled(exp_match)), 48'($sampled(match)));

	//--------------------------------------------------------------------
	// Test sequence
	//--------------------------------------------------------------------
	initial begin
		int errs;
		int n;
		int bad;
		int s0;
		int v0;
		int m0;
		logic [15:0] w[3];
		logic [47:0] v;
		err_cnt  = 0;
		test_cnt = 0;
		fail_cnt = 0;
		void'($urandom(89753));
		cmp_rx_resetdone = 1'b0;
		rst              = 1'b0;
		rx_byte_aligned  = 1'b0;
		repeat (2) @(posedge CMP_RX_CLK160);
		#1;
		cmp_rx_resetdone = 1'b1;

		// Phase-alignment bring-up within an 80 cycle budget
		errs = err_cnt;
		assert (dlyaligndisable)
			else report_mismatch("dlyaligndisable", 48'd1, 48'(dlyaligndisable));
		assert (!sync_done)
			else report_mismatch("sync_done", 48'd0, 48'(sync_done));
		assert (!pmasetphase)
			else report_mismatch("pmasetphase", 48'd0, 48'(pmasetphase));
		assert (!enpmaphasealign)
			else report_mismatch("enpmaphasealign", 48'd0, 48'(enpmaphasealign));
		n = 0;
		while (n < 10 && !dlyalignreset) begin
			@(posedge CMP_RX_CLK160);
			#1;
			n++;
		end
		assert (dlyalignreset) else log_failure("dlyalignreset never asserted");
		while (n < 80 && !enpmaphasealign) begin
			@(posedge CMP_RX_CLK160);
			#1;
			n++;
		end
		assert (enpmaphasealign) else log_failure("enpmaphasealign never asserted");
		while (n < 80 && !sync_done) begin
			@(posedge CMP_RX_CLK160);
			#1;
			n++;
		end
		assert (sync_done) else log_failure("sync_done not high within 80 cycles");
		finish_test("link bring-up", errs);

		// Comma align enable
		errs = err_cnt;
		assert (calign_en) else report_mismatch("calign_en", 48'd1, 48'(calign_en));
		@(posedge CMP_RX_CLK160);
		#1;
		rx_byte_aligned = 1'b1;
		for (n = 0; n < 5 && calign_en; n++) begin
			@(posedge CMP_RX_CLK160);
			#1;
		end
		assert (!calign_en) else log_failure("calign_en stayed high after byte alignment");
		rx_byte_aligned = 1'b0;
		for (n = 0; n < 5 && !calign_en; n++) begin
			@(posedge CMP_RX_CLK160);
			#1;
		end
		assert (calign_en) else log_failure("calign_en stayed low after alignment loss");
		rx_byte_aligned = 1'b1;
		finish_test("comma align enable", errs);

		// Random payloads with about one word in four zero
		errs = err_cnt;
		for (n = 0; n < 24; n++) begin
			for (int i = 0; i < 3; i++) begin
				w[i] = 16'($urandom());
				if ($urandom() % 4 == 0)
					w[i] = '0;
			end
			send_checked(cmp_rx_pkg::k_sync, {w[2], w[1], w[0]});
			tx_model_inst.send_idle(int'($urandom() % 3));
		end
		drain();
		finish_test("random frames", errs);

		// Latency marker on and off
		errs = err_cnt;
		send_checked(cmp_rx_pkg::k_latency, 48'h1234_5678_9ABC);
		send_checked(cmp_rx_pkg::k_sync, 48'h0000_1111_0000);
		send_checked(cmp_rx_pkg::k_latency, 48'h0000_0000_0000);
		send_checked(cmp_rx_pkg::k_sync, 48'hFEDC_0000_0001);
		drain();
		finish_test("latency trigger", errs);

		// Start pattern and eight PRBS frames with one bad bit
		errs = err_cnt;
		s0 = strt_cnt;
		v0 = valid_cnt;
		m0 = match_cnt;
		bad = int'($urandom() % 48);
		v = cmp_rx_pkg::prbs_start_pattern;
		send_checked(cmp_rx_pkg::k_sync, v);
		for (n = 0; n < 8; n++) begin
			v = lfsr_step(v);
			if (n == 4)
				send_checked(cmp_rx_pkg::k_sync, v ^ (48'd1 << bad));
			else
				send_checked(cmp_rx_pkg::k_sync, v);
		end
		drain();
		assert (strt_cnt - s0 == 1)
			else report_mismatch("strt_mtch pulse count", 48'd1, 48'(strt_cnt - s0));
		assert (valid_cnt - v0 == 8)
			else report_mismatch("valid pulse count", 48'd8, 48'(valid_cnt - v0));
		assert (match_cnt - m0 == 7)
			else report_mismatch("match pulse count", 48'd7, 48'(match_cnt - m0));
		finish_test("prbs check", errs);

		// Checking resumes only on a new start pattern after rst
		errs = err_cnt;
		s0 = strt_cnt;
		v0 = valid_cnt;
		m0 = match_cnt;
		@(posedge CMP_RX_CLK160);
		#1;
		rst = 1'b1;
		@(posedge CMP_RX_CLK160);
		#1;
		rst = 1'b0;
		for (n = 0; n < 3; n++) begin
			v = lfsr_step(v);
			send_checked(cmp_rx_pkg::k_sync, v);
		end
		drain();
		assert (valid_cnt == v0)
			else report_mismatch("valid pulses after rst", 48'd0, 48'(valid_cnt - v0));
		send_checked(cmp_rx_pkg::k_sync, cmp_rx_pkg::prbs_start_pattern);
		send_checked(cmp_rx_pkg::k_sync, lfsr_step(cmp_rx_pkg::prbs_start_pattern));
		drain();
		assert (strt_cnt - s0 == 1)
			else report_mismatch("strt_mtch pulse count", 48'd1, 48'(strt_cnt - s0));
		assert (match_cnt - m0 == 1)
			else report_mismatch("match pulse count", 48'd1, 48'(match_cnt - m0));
		finish_test("checker clear", errs);

		$display("tests run %0d, with errors %0d, error count %0d", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Whole-run limit behind the per-wait bounds
	initial begin
		#100us;
		$display("Simulation stopped at the overall time limit");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/cmp_fiber_tx_model.sv
`default_nettype none

module cmp_fiber_tx_model (
	input  logic        CMP_RX_CLK160,
	output logic [15:0] rx_data,
	output logic [1:0]  rx_isk
);

	timeunit 1ns;
	timeprecision 1ps;

	// Upper byte of every marker word, not a K char
	localparam logic [7:0] marker_hi = 8'h50;

	// Line idles as plain zero data until the first word
	initial begin
		rx_data = '0;
		rx_isk  = 2'b00;
	end

	//--------------------------------------------------------------------
	// Word level
	//--------------------------------------------------------------------
	// One word per recovered clock, launched just after the edge
	task automatic put_word(input logic [15:0] data, input logic [1:0] isk);
		@(posedge CMP_RX_CLK160);
		#1;
		rx_data = data;
		rx_isk  = isk;
	endtask

	// Filler between frames, never a marker
	task automatic send_idle(input int count);
		for (int i = 0; i < count; i++)
			put_word(16'h0000, 2'b00);
	endtask

	//--------------------------------------------------------------------
	// Frame level
	//--------------------------------------------------------------------
	// K code in the low byte, then w1 w2 w3
	task automatic send_frame(input logic [7:0] k, input logic [15:0] w1,
		input logic [15:0] w2, input logic [15:0] w3);
		put_word({marker_hi, k}, 2'b01);
		put_word(w1, 2'b00);
		put_word(w2, 2'b00);
		put_word(w3, 2'b00);
	endtask

endmodule

`default_nettype wire

// File: rtl/cmp_fiber_rx.sv
`default_nettype none

module cmp_fiber_rx (
	input  logic                                CMP_RX_CLK160,
	input  logic                                cmp_rx_resetdone,
	input  logic                                rst,
	input  logic [15:0]                         rx_data,
	input  logic [1:0]                          rx_isk,
	input  logic                                rx_byte_aligned,
	output logic                                calign_en,
	output logic                                enpmaphasealign,
	output logic                                pmasetphase,
	output logic                                dlyaligndisable,
	output logic                                dlyalignreset,
	output logic                                sync_done,
	output logic [47:0]                         rcv_data,
	output logic [cmp_rx_pkg::frame_words-1:0]  nonzero_word,
	output logic                                ltncy_trig,
	output logic                                strt_mtch,
	output logic                                valid,
	output logic                                match
);

	// Frame path from assembler to checker
	cmp_frame_if frame_if ();

	//--------------------------------------------------------------------
	// Link bring-up
	//--------------------------------------------------------------------
	cmp_rx_link_ctrl link_ctrl_inst (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rx_byte_aligned  (rx_byte_aligned),
		.calign_en        (calign_en),
		.enpmaphasealign  (enpmaphasealign),
		.pmasetphase      (pmasetphase),
		.dlyaligndisable  (dlyaligndisable),
		.dlyalignreset    (dlyalignreset),
		.sync_done        (sync_done)
	);

	//--------------------------------------------------------------------
	// Receive data
	//--------------------------------------------------------------------
	cmp_frame_assembler frame_assembler_inst (
		.CMP_RX_CLK160 (CMP_RX_CLK160),
		.rx_data       (rx_data),
		.rx_isk        (rx_isk),
		.frame         (frame_if.assembler)
	);

	cmp_prbs_checker prbs_checker_inst (
		.CMP_RX_CLK160    (CMP_RX_CLK160),
		.cmp_rx_resetdone (cmp_rx_resetdone),
		.rst              (rst),
		.frame            (frame_if.check),
		.strt_mtch        (strt_mtch),
		.valid            (valid),
		.match            (match)
	);

	// Frame fields out to the pins
	assign rcv_data     = frame_if.rcv_data;
	assign nonzero_word = frame_if.nonzero_word;
	assign ltncy_trig   = frame_if.ltncy_trig;

endmodule

`default_nettype wire

// File: rtl/cmp_prbs_checker.sv
`default_nettype none

module cmp_prbs_checker (
	input  logic          CMP_RX_CLK160,
	input  logic          cmp_rx_resetdone,
	input  logic          rst,
	cmp_frame_if.check    frame,
	output logic          strt_mtch,
	output logic          valid,
	output logic          match
);

	// Set once the start pattern is seen
	logic locked;
	// Expected value of the next frame
	logic [47:0] predict;

	//--------------------------------------------------------------------
	// LFSR step
	//--------------------------------------------------------------------
	// Shift up one with the feedback into bit 0
	function automatic logic [47:0] prbs_next(input logic [47:0] v);
		logic fb;
		fb = v[cmp_rx_pkg::prbs_tap_hi] ^ v[cmp_rx_pkg::prbs_tap_a] ^
			v[cmp_rx_pkg::prbs_tap_b] ^ v[cmp_rx_pkg::prbs_tap_lo];
		return {v[46:0], fb};
	endfunction

	//--------------------------------------------------------------------
	// Lock and compare
	//--------------------------------------------------------------------
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			locked    <= 1'b0;
			strt_mtch <= 1'b0;
			valid     <= 1'b0;
			match     <= 1'b0;
		end else begin
			// Status bits are single-cycle pulses
			strt_mtch <= 1'b0;
			valid     <= 1'b0;
			match     <= 1'b0;
			if (rst) begin
				locked <= 1'b0;
			end else if (frame.frame_ready) begin
				if (!locked) begin
					// Hunt for the start frame
					if (frame.rcv_data == cmp_rx_pkg::prbs_start_pattern) begin
						strt_mtch <= 1'b1;
						locked    <= 1'b1;
					end
				end else begin
					valid <= 1'b1;
					match <= (frame.rcv_data == predict);
				end
			end
		end
	end

	//--------------------------------------------------------------------
	// Predictor
	//--------------------------------------------------------------------
	// While unlocked the received frame seeds the next prediction
	// Once locked it free-runs and a bad frame costs one miss only
	always_ff @(posedge CMP_RX_CLK160) begin
		if (frame.frame_ready) begin
			if (locked)
				predict <= prbs_next(predict);
			else
				predict <= prbs_next(frame.rcv_data);
		end
	end

endmodule

`default_nettype wire

// File: rtl/cmp_frame_assembler.sv
`default_nettype none

module cmp_frame_assembler (
	input  logic                CMP_RX_CLK160,
	input  logic [15:0]         rx_data,
	input  logic [1:0]          rx_isk,
	cmp_frame_if.assembler      frame
);

	localparam int last = cmp_rx_pkg::frame_words - 1;

	// Marker word, K char in the low byte only
	logic marker;
	// Word enables, bit i captures data word i+1
	logic [last:0] word_en;
	// Early words held until the last one lands
	logic [last-1:0][15:0] word_q;
	logic [last-1:0]       nz_q;
	// Latency flag of the current marker
	logic ltncy_hold;

	assign marker = (rx_isk == 2'b01);

	//--------------------------------------------------------------------
	// Word enable chain
	//--------------------------------------------------------------------
	// Free running, restarts on every marker
	always_ff @(posedge CMP_RX_CLK160) begin
		word_en <= {word_en[last-1:0], marker};
		// Strobe trails the publishing enable by one edge
		frame.frame_ready <= word_en[last];
	end

	//--------------------------------------------------------------------
	// Word capture
	//--------------------------------------------------------------------
	always_ff @(posedge CMP_RX_CLK160) begin
		// Latency K code seen on the marker itself
		if (marker)
			ltncy_hold <= (rx_data[7:0] == cmp_rx_pkg::k_latency);

		// w1 and w2 with their nonzero flags
		for (int i = 0; i < last; i++) begin
			if (word_en[i]) begin
				word_q[i] <= rx_data;
				nz_q[i]   <= |rx_data;
			end
		end

		// w3 completes the frame, publish all at once
		if (word_en[last]) begin
			frame.rcv_data     <= {rx_data, word_q};
			frame.nonzero_word <= {|rx_data, nz_q};
			frame.ltncy_trig   <= ltncy_hold;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cmp_rx_link_ctrl.sv
`default_nettype none

module cmp_rx_link_ctrl (
	input  logic CMP_RX_CLK160,
	input  logic cmp_rx_resetdone,
	input  logic rx_byte_aligned,
	output logic calign_en,
	output logic enpmaphasealign,
	output logic pmasetphase,
	output logic dlyaligndisable,
	output logic dlyalignreset,
	output logic sync_done
);

	// Reset-done release stages
	logic resetdone_r;
	logic resetdone_r2;

	// Sequencer state and its shared hold counter
	cmp_rx_pkg::link_state_e state;
	cmp_rx_pkg::seq_cnt_t    cnt;

	//--------------------------------------------------------------------
	// Reset-done synchronizer
	//--------------------------------------------------------------------
	// Assert at once, release after two recovered-clock edges
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			resetdone_r  <= 1'b0;
			resetdone_r2 <= 1'b0;
		end else begin
			resetdone_r  <= 1'b1;
			resetdone_r2 <= resetdone_r;
		end
	end

	//--------------------------------------------------------------------
	// Comma alignment enable
	//--------------------------------------------------------------------
	// Keep searching for commas until the byte boundary is found
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone)
			calign_en <= 1'b1;
		else
			calign_en <= !rx_byte_aligned;
	end

	//--------------------------------------------------------------------
	// Phase-alignment sequencer
	//--------------------------------------------------------------------
	always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
		if (!cmp_rx_resetdone) begin
			state           <= cmp_rx_pkg::st_wait_reset;
			cnt             <= '0;
			dlyalignreset   <= 1'b0;
			dlyaligndisable <= 1'b1;
			enpmaphasealign <= 1'b0;
			pmasetphase     <= 1'b0;
			sync_done       <= 1'b0;
		end else begin
			case (state)
				// Idle until the synchronized release arrives
				cmp_rx_pkg::st_wait_reset: begin
					if (resetdone_r2) begin
						state         <= cmp_rx_pkg::st_dly_reset;
						cnt           <= cmp_rx_pkg::dly_reset_cycles - 1'b1;
						dlyalignreset <= 1'b1;
					end
				end
				// Hold the delay aligner in reset
				cmp_rx_pkg::st_dly_reset: begin
					if (cnt == '0) begin
						state         <= cmp_rx_pkg::st_pma_align;
						dlyalignreset <= 1'b0;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				// One gap cycle, then phase alignment on and stays on
				cmp_rx_pkg::st_pma_align: begin
					state           <= cmp_rx_pkg::st_set_phase;
					enpmaphasealign <= 1'b1;
					pmasetphase     <= 1'b1;
					cnt             <= cmp_rx_pkg::set_phase_cycles - 1'b1;
				end
				// PMA set-phase window
				cmp_rx_pkg::st_set_phase: begin
					if (cnt == '0) begin
						state           <= cmp_rx_pkg::st_done;
						pmasetphase     <= 1'b0;
						dlyaligndisable <= 1'b0;
						sync_done       <= 1'b1;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				// Locked phase, hold until the next reset
				cmp_rx_pkg::st_done: begin
					sync_done <= 1'b1;
				end
				default: begin
					state <= cmp_rx_pkg::st_wait_reset;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/cmp_frame_if.sv
`default_nettype none

interface cmp_frame_if;

	// Assembled payload w3 w2 w1 from high to low
	logic [47:0] rcv_data;
	// One flag per data word with w1 in bit 0
	logic [cmp_rx_pkg::frame_words-1:0] nonzero_word;
	// Marker of this frame was the latency K code
	logic ltncy_trig;
	// Single-cycle strobe in the first cycle of a new rcv_data
	logic frame_ready;

	// Frame builder side
	modport assembler (
		output rcv_data,
		output nonzero_word,
		output ltncy_trig,
		output frame_ready
	);

	// PRBS checker side
	modport check (
		input rcv_data,
		input nonzero_word,
		input ltncy_trig,
		input frame_ready
	);

endinterface

`default_nettype wire

// File: rtl/cmp_rx_pkg.sv
`default_nettype none

package cmp_rx_pkg;

	//--------------------------------------------------------------------
	// Buffer-bypass phase-alignment sequencer
	//--------------------------------------------------------------------
	typedef enum logic [2:0] {
		st_wait_reset,
		st_dly_reset,
		st_pma_align,
		st_set_phase,
		st_done
	} link_state_e;

	// Sequencer down-counter, wide enough for the longest hold
	typedef logic [5:0] seq_cnt_t;

	// Delay-align reset hold
	localparam seq_cnt_t dly_reset_cycles = 6'd16;
	// PMA set-phase hold
	localparam seq_cnt_t set_phase_cycles = 6'd32;

	//--------------------------------------------------------------------
	// Framing
	//--------------------------------------------------------------------
	// K characters carried in the marker low byte
	typedef enum logic [7:0] {
		k_sync    = 8'hBC,
		k_latency = 8'hFC
	} k_code_e;

	// Data words after each marker
	localparam int frame_words = 3;

	//--------------------------------------------------------------------
	// PRBS
	//--------------------------------------------------------------------
	localparam logic [47:0] prbs_start_pattern = 48'hFFFFFF000000;

	// Feedback taps for the new LFSR bit
	localparam int prbs_tap_hi = 47;
	localparam int prbs_tap_a  = 46;
	localparam int prbs_tap_b  = 20;
	localparam int prbs_tap_lo = 19;

endpackage

`default_nettype wire
